// ==== build.f ====
trace_pkg.sv
trace_capture.sv
trace_storage.sv
trace_csr.sv
trace_buffer_top.sv
tb_trace_buffer.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the trace buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_trace_buffer -f build.f

# Output stays in memory and is searched for the pass line
out=$(./obj_dir/Vtb_trace_buffer)
echo "$out"

if echo "$out" | grep -qx "PASS: all tests"; then
    exit 0
else
    exit 1
fi

// ==== tb_trace_buffer.sv ====
`timescale 1ns/1ps

module tb_trace_buffer;

    localparam int         NUM_ENTRIES = 8;
    localparam int         DEPTH_DW    = NUM_ENTRIES * 4;
    localparam logic [6:0] DMI_ADDR    = 7'h5D;

    // Register offsets as plain integers for the table
    localparam int REG_STATUS = int'(trace_pkg::TRACE_STATUS_OFFS);
    localparam int REG_CONFIG = int'(trace_pkg::TRACE_CONFIG_OFFS);
    localparam int REG_WR_PTR = int'(trace_pkg::TRACE_WR_PTR_OFFS);
    localparam int REG_RD_PTR = int'(trace_pkg::TRACE_RD_PTR_OFFS);
    localparam int REG_DATA   = int'(trace_pkg::TRACE_DATA_OFFS);

    // Row operations
    localparam logic [2:0] OP_TRACE     = 3'd0;
    localparam logic [2:0] OP_RD        = 3'd1;
    localparam logic [2:0] OP_WR        = 3'd2;
    localparam logic [2:0] OP_DMI       = 3'd3;
    localparam logic [2:0] OP_DEBUG     = 3'd4;
    localparam logic [2:0] OP_VIEW      = 3'd5;
    localparam logic [2:0] OP_VIEW_ZERO = 3'd6;

    // One stimulus row
    // from_model takes the expected dword from the model
    typedef struct packed {
        logic [2:0]  op;
        logic [6:0]  addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [31:0] exp_data;
        logic        exp_err;
        logic        from_model;
    } row_t;

    logic                       clk, rst_b, debug_en;
    logic                       trace_valid, trace_exception, trace_interrupt;
    logic [31:0]                trace_insn, trace_address, trace_tval;
    logic [4:0]                 trace_ecause;
    logic                       fab_valid, fab_error, dmi_wen;
    trace_pkg::fabric_req_t     fab_req;
    logic [31:0]                fab_rdata, dmi_wdata;
    logic [6:0]                 dmi_addr;
    trace_pkg::trace_dmi_view_t dmi_view;

    // Expected buffer contents and pointers
    logic [31:0] model_mem [NUM_ENTRIES][4];
    int          model_wr;
    int          model_rd_ptr;
    logic        model_dbg;
    logic [31:0] lfsr;
    int          errors;
    int          checks;
    row_t        rows[$];

    trace_buffer_top #(
        .NUM_ENTRIES     (NUM_ENTRIES),
        .DMI_RD_PTR_ADDR (DMI_ADDR)
    ) DUT (
        .clk (clk), .rst_b (rst_b), .debug_en (debug_en),
        .trace_valid (trace_valid), .trace_insn (trace_insn),
        .trace_address (trace_address), .trace_tval (trace_tval),
        .trace_exception (trace_exception), .trace_ecause (trace_ecause),
        .trace_interrupt (trace_interrupt),
        .fab_valid (fab_valid), .fab_req (fab_req),
        .fab_rdata (fab_rdata), .fab_error (fab_error),
        .dmi_wen (dmi_wen), .dmi_addr (dmi_addr), .dmi_wdata (dmi_wdata),
        .dmi_view (dmi_view)
    );

    always #2 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1
    // Stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // Byte strobes applied to the old pointer, then wrapped to the depth
    function automatic logic [31:0] merge_strobes(input logic [31:0] old,
                                                  input logic [31:0] wdata,
                                                  input logic [3:0]  strb);
        logic [31:0] v;
        v = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) v[8*b +: 8] = wdata[8*b +: 8];
        end
        return v % 32'(DEPTH_DW);
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, act);
        end
    endtask

    task automatic add_row(input logic [2:0] op, input int addr, input int data,
                           input int strb, input int exp_data, input int err,
                           input int model);
        rows.push_back(row_t'{op, 7'(addr), 32'(data), 4'(strb), 32'(exp_data), 1'(err),
                              1'(model)});
    endtask

    // Point READ_PTR at each dword in turn and read DATA against the model
    task automatic add_readback(input int first, input int last);
        for (int d = first; d <= last; d++) begin
            add_row(OP_WR, REG_RD_PTR, d, 4'hF, 0, 0, 0);
            add_row(OP_RD, REG_DATA, 0, 0, 0, 0, 1);
        end
    endtask

    task automatic apply_row(input row_t r);
        logic [31:0] ins, adr, tv, cause, exp;
        @(posedge clk);
        trace_valid <= 1'b0;
        fab_valid   <= 1'b0;
        dmi_wen     <= 1'b0;
        case (r.op)
            OP_TRACE: begin
                ins   = rand_bits(32);
                adr   = rand_bits(32);
                tv    = rand_bits(32);
                // Cause dword holds exception in bit 0, ecause in 5:1, interrupt in bit 6
                cause = rand_bits(7);
                trace_valid     <= 1'b1;
                trace_insn      <= ins;
                trace_address   <= adr;
                trace_tval      <= tv;
                trace_exception <= cause[0];
                trace_ecause    <= cause[5:1];
                trace_interrupt <= cause[6];
                if (model_dbg) begin
                    model_mem[model_wr][0] = ins;
                    model_mem[model_wr][1] = adr;
                    model_mem[model_wr][2] = tv;
                    model_mem[model_wr][3] = {25'd0, cause[6:0]};
                    model_wr = (model_wr + 1) % NUM_ENTRIES;
                end
            end
            OP_RD: begin
                fab_valid <= 1'b1;
                fab_req   <= '{addr: r.addr, write: 1'b0, wdata: 32'd0, wstrb: 4'd0};
            end
            OP_WR: begin
                fab_valid <= 1'b1;
                fab_req   <= '{addr: r.addr, write: 1'b1, wdata: r.data, wstrb: r.strb};
                if (model_dbg && r.addr == trace_pkg::TRACE_RD_PTR_OFFS)
                    model_rd_ptr = merge_strobes(32'(model_rd_ptr), r.data, r.strb);
            end
            OP_DMI: begin
                dmi_wen   <= 1'b1;
                dmi_addr  <= r.addr;
                dmi_wdata <= r.data;
                if (model_dbg && r.addr == DMI_ADDR)
                    model_rd_ptr = int'(r.data % 32'(DEPTH_DW));
            end
            OP_DEBUG: begin
                debug_en  <= r.data[0];
                model_dbg = r.data[0];
            end
            default: ;
        endcase
        // Responses are combinational
        // Sample them half a cycle later
        @(negedge clk);
        exp = r.from_model ? model_mem[model_rd_ptr / 4][model_rd_ptr % 4] : r.exp_data;
        case (r.op)
            OP_RD: begin
                check_value("fab_rdata", exp, fab_rdata);
                check_value("fab_error", 32'(r.exp_err), 32'(fab_error));
            end
            OP_WR: check_value("fab_error", 32'(r.exp_err), 32'(fab_error));
            OP_VIEW: begin
                check_value("dmi_view.rd_ptr", r.exp_data, dmi_view.rd_ptr);
                check_value("dmi_view.data", model_mem[model_rd_ptr / 4][model_rd_ptr % 4],
                            dmi_view.data);
            end
            OP_VIEW_ZERO: begin
                check_value("dmi_view.status", 32'd0, dmi_view.status);
                check_value("dmi_view.cfg", 32'd0, dmi_view.cfg);
                check_value("dmi_view.wr_ptr", 32'd0, dmi_view.wr_ptr);
                check_value("dmi_view.rd_ptr", 32'd0, dmi_view.rd_ptr);
                check_value("dmi_view.data", 32'd0, dmi_view.data);
            end
            default: begin
                // Idle fabric port answers nothing
                check_value("fab_rdata", 32'd0, fab_rdata);
                check_value("fab_error", 32'd0, 32'(fab_error));
            end
        endcase
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus table and run
    //////////////////////////////////////////////////////////////////////
    initial begin
        int   cnt;
        logic ready;
        lfsr = 32'h8300;
        {errors, checks, model_wr, model_rd_ptr} = '0;
        model_dbg = 1'b1;
        {clk, rst_b, debug_en} = 3'b001;
        {trace_valid, trace_exception, trace_interrupt, trace_ecause} = '0;
        {trace_insn, trace_address, trace_tval} = '0;
        {fab_valid, dmi_wen, dmi_addr, dmi_wdata} = '0;
        fab_req = '0;
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            for (int d = 0; d < 4; d++) model_mem[e][d] = '0;
        end

        // Reset state
        add_row(OP_RD, REG_STATUS, 0, 0, 0, 0, 0);
        add_row(OP_RD, REG_CONFIG, 0, 0, DEPTH_DW, 0, 0);
        add_row(OP_RD, REG_WR_PTR, 0, 0, 0, 0, 0);
        add_row(OP_RD, REG_RD_PTR, 0, 0, 0, 0, 0);
        // Three entries and their readback
        repeat (3) add_row(OP_TRACE, 0, 0, 0, 0, 0, 0);
        add_row(OP_RD, REG_WR_PTR, 0, 0, 12, 0, 0);
        add_row(OP_RD, REG_STATUS, 0, 0, 1, 0, 0);
        add_readback(0, 11);
        // Wrap past the last entry
        repeat (9) add_row(OP_TRACE, 0, 0, 0, 0, 0, 0);
        add_row(OP_RD, REG_WR_PTR, 0, 0, 16, 0, 0);
        add_row(OP_RD, REG_STATUS, 0, 0, 3, 0, 0);
        add_readback(0, DEPTH_DW - 1);
        // Byte strobes, read-only registers, unmapped offsets
        add_row(OP_WR, REG_RD_PTR, 32'h15, 4'hF, 0, 0, 0);
        add_row(OP_RD, REG_RD_PTR, 0, 0, 32'h15, 0, 0);
        add_row(OP_WR, REG_RD_PTR, 32'hFFFF_FF0A, 4'h1, 0, 0, 0);
        add_row(OP_RD, REG_RD_PTR, 0, 0, 32'h0A, 0, 0);
        add_row(OP_RD, REG_DATA, 0, 0, 0, 0, 1);
        add_row(OP_WR, REG_RD_PTR, 32'h0000_1F00, 4'h2, 0, 0, 0);
        add_row(OP_RD, REG_RD_PTR, 0, 0, 32'h0A, 0, 0);
        add_row(OP_WR, REG_STATUS, 32'h1F, 4'hF, 0, 1, 0);
        add_row(OP_RD, REG_STATUS, 0, 0, 3, 0, 0);
        add_row(OP_WR, REG_WR_PTR, 32'h1F, 4'hF, 0, 1, 0);
        add_row(OP_RD, REG_WR_PTR, 0, 0, 16, 0, 0);
        add_row(OP_RD, REG_RD_PTR, 0, 0, 32'h0A, 0, 0);
        add_row(OP_RD, 7'h14, 0, 0, 0, 1, 0);
        add_row(OP_WR, 7'h02, 1, 4'hF, 0, 1, 0);
        // DMI pointer writes
        // Only one address is live
        add_row(OP_DMI, DMI_ADDR, 5, 0, 0, 0, 0);
        add_row(OP_VIEW, 0, 0, 0, 5, 0, 0);
        add_row(OP_RD, REG_RD_PTR, 0, 0, 5, 0, 0);
        add_row(OP_DMI, DMI_ADDR - 1, 9, 0, 0, 0, 0);
        add_row(OP_VIEW, 0, 0, 0, 5, 0, 0);
        // Debug off closes both ports
        add_row(OP_DEBUG, 0, 0, 0, 0, 0, 0);
        repeat (2) add_row(OP_TRACE, 0, 0, 0, 0, 0, 0);
        add_row(OP_RD, REG_WR_PTR, 0, 0, 0, 1, 0);
        add_row(OP_RD, REG_STATUS, 0, 0, 0, 1, 0);
        add_row(OP_RD, REG_DATA, 0, 0, 0, 1, 0);
        add_row(OP_WR, REG_RD_PTR, 3, 4'hF, 0, 1, 0);
        add_row(OP_DMI, DMI_ADDR, 7, 0, 0, 0, 0);
        add_row(OP_VIEW_ZERO, 0, 0, 0, 0, 0, 0);
        // Contents come back untouched
        add_row(OP_DEBUG, 0, 1, 0, 0, 0, 0);
        add_row(OP_RD, REG_WR_PTR, 0, 0, 16, 0, 0);
        add_row(OP_RD, REG_STATUS, 0, 0, 3, 0, 0);
        add_row(OP_RD, REG_RD_PTR, 0, 0, 5, 0, 0);
        add_readback(0, DEPTH_DW - 1);

        repeat (16) @(posedge clk);
        rst_b <= 1'b1;

        // Wait until the debug view shows the reset state
        ready = 1'b0;
        for (cnt = 0; cnt < 10 && !ready; cnt++) begin
            @(negedge clk);
            ready = (dmi_view.cfg === 32'(DEPTH_DW)) && (dmi_view.status === 32'd0) &&
                    (dmi_view.wr_ptr === 32'd0) && (dmi_view.rd_ptr === 32'd0);
        end
        if (!ready) begin
            $display("Timeout: DUT did not show its reset state after reset release");
            errors++;
        end else begin
            foreach (rows[i]) apply_row(rows[i]);
            @(posedge clk);
            trace_valid <= 1'b0;
            fab_valid   <= 1'b0;
            dmi_wen     <= 1'b0;
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== trace_buffer_top.sv ====
`timescale 1ns/1ps

module trace_buffer_top #(
    parameter int         NUM_ENTRIES     = 16,
    parameter logic [6:0] DMI_RD_PTR_ADDR = 7'h5D
) (
    input  logic                       clk,
    input  logic                       rst_b,
    input  logic                       debug_en,
    // Retired instruction trace
    input  logic                       trace_valid,
    input  logic [31:0]                trace_insn,
    input  logic [31:0]                trace_address,
    input  logic [31:0]                trace_tval,
    input  logic                       trace_exception,
    input  logic [4:0]                 trace_ecause,
    input  logic                       trace_interrupt,
    // Internal fabric
    input  logic                       fab_valid,
    input  trace_pkg::fabric_req_t     fab_req,
    output logic [31:0]                fab_rdata,
    output logic                       fab_error,
    // Debug module
    input  logic                       dmi_wen,
    input  logic [6:0]                 dmi_addr,
    input  logic [31:0]                dmi_wdata,
    output trace_pkg::trace_dmi_view_t dmi_view
);

    localparam int PTR_W = $clog2(NUM_ENTRIES);

    //////////////////////////////////////////////////////////////////////
    // Internal wires
    //////////////////////////////////////////////////////////////////////

    // Capture to storage
    logic                    wr_en;
    logic [PTR_W-1:0]        wr_idx;
    trace_pkg::trace_entry_u wr_entry;

    // Capture to register block
    logic [31:0]             wr_ptr_dw;
    logic                    valid_data;
    logic                    wrapped;

    // Register block and storage read port
    logic [31:0]             rd_ptr_dw;
    logic [31:0]             rd_dword;

    trace_capture #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) u_capture (
        .clk             (clk),
        .rst_b           (rst_b),
        .debug_en        (debug_en),
        .trace_valid     (trace_valid),
        .trace_insn      (trace_insn),
        .trace_address   (trace_address),
        .trace_tval      (trace_tval),
        .trace_exception (trace_exception),
        .trace_ecause    (trace_ecause),
        .trace_interrupt (trace_interrupt),
        .wr_en           (wr_en),
        .wr_idx          (wr_idx),
        .wr_entry        (wr_entry),
        .wr_ptr_dw       (wr_ptr_dw),
        .valid_data      (valid_data),
        .wrapped         (wrapped)
    );

    trace_storage #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) u_storage (
        .clk       (clk),
        .rst_b     (rst_b),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_entry  (wr_entry),
        .rd_ptr_dw (rd_ptr_dw),
        .rd_dword  (rd_dword)
    );

    trace_csr #(
        .NUM_ENTRIES     (NUM_ENTRIES),
        .DMI_RD_PTR_ADDR (DMI_RD_PTR_ADDR)
    ) u_csr (
        .clk        (clk),
        .rst_b      (rst_b),
        .debug_en   (debug_en),
        .fab_valid  (fab_valid),
        .fab_req    (fab_req),
        .fab_rdata  (fab_rdata),
        .fab_error  (fab_error),
        .dmi_wen    (dmi_wen),
        .dmi_addr   (dmi_addr),
        .dmi_wdata  (dmi_wdata),
        .dmi_view   (dmi_view),
        .wr_ptr_dw  (wr_ptr_dw),
        .valid_data (valid_data),
        .wrapped    (wrapped),
        .rd_dword   (rd_dword),
        .rd_ptr_dw  (rd_ptr_dw)
    );

endmodule

// ==== trace_csr.sv ====
`timescale 1ns/1ps

module trace_csr #(
    parameter int         NUM_ENTRIES     = 16,
    parameter logic [6:0] DMI_RD_PTR_ADDR = 7'h5D
) (
    input  logic                       clk,
    input  logic                       rst_b,
    input  logic                       debug_en,
    // Fabric port
    input  logic                       fab_valid,
    input  trace_pkg::fabric_req_t     fab_req,
    output logic [31:0]                fab_rdata,
    output logic                       fab_error,
    // Debug module port
    input  logic                       dmi_wen,
    input  logic [6:0]                 dmi_addr,
    input  logic [31:0]                dmi_wdata,
    output trace_pkg::trace_dmi_view_t dmi_view,
    // Capture state
    input  logic [31:0]                wr_ptr_dw,
    input  logic                       valid_data,
    input  logic                       wrapped,
    // Storage read port
    input  logic [31:0]                rd_dword,
    output logic [31:0]                rd_ptr_dw
);

    // Buffer depth in dwords
    localparam int DEPTH_DW = NUM_ENTRIES * trace_pkg::TRACE_ENTRY_DWORDS;

    // Decode results
    logic        fab_hit;
    logic        fab_rd_ptr_sel;
    logic [31:0] fab_word;
    logic        fab_wr_ok;
    logic        dmi_wr_ok;

    // READ_PTR update path
    logic [31:0] wr_mask;
    logic [31:0] fab_rd_ptr_new;

    // Register words before debug gating
    trace_pkg::trace_dmi_view_t regs;

    //////////////////////////////////////////////////////////////////////
    // Register words
    //////////////////////////////////////////////////////////////////////
    assign regs.status = {30'd0, wrapped, valid_data};
    assign regs.cfg    = 32'(DEPTH_DW);
    assign regs.wr_ptr = wr_ptr_dw;
    assign regs.rd_ptr = rd_ptr_dw;
    assign regs.data   = rd_dword;

    // Debug module sees nothing while debug is off
    assign dmi_view = debug_en ? regs : '0;

    //////////////////////////////////////////////////////////////////////
    // Fabric decode
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        fab_hit  = 1'b1;
        fab_word = '0;
        case (fab_req.addr)
            trace_pkg::TRACE_STATUS_OFFS: fab_word = regs.status;
            trace_pkg::TRACE_CONFIG_OFFS: fab_word = regs.cfg;
            trace_pkg::TRACE_WR_PTR_OFFS: fab_word = regs.wr_ptr;
            trace_pkg::TRACE_RD_PTR_OFFS: fab_word = regs.rd_ptr;
            trace_pkg::TRACE_DATA_OFFS:   fab_word = regs.data;
            default:                      fab_hit  = 1'b0;
        endcase
    end

    // Only READ_PTR takes writes
    assign fab_rd_ptr_sel = (fab_req.addr == trace_pkg::TRACE_RD_PTR_OFFS);

    // Closed port, unmapped offset or write to a read-only register
    assign fab_error = fab_valid &
                       (~debug_en | ~fab_hit | (fab_req.write & ~fab_rd_ptr_sel));

    // Read data only for a good read, zero otherwise
    assign fab_rdata = (fab_valid & ~fab_error & ~fab_req.write) ? fab_word : '0;

    //////////////////////////////////////////////////////////////////////
    // READ_PTR register
    //////////////////////////////////////////////////////////////////////

    // One strobe bit covers eight data bits
    always_comb begin
        for (int i = 0; i < 32; i++) begin
            wr_mask[i] = fab_req.wstrb[i / 8];
        end
    end

    // Merge strobed bytes into the current pointer
    assign fab_rd_ptr_new = (rd_ptr_dw & ~wr_mask) | (fab_req.wdata & wr_mask);

    assign fab_wr_ok = fab_valid & debug_en & fab_req.write & fab_rd_ptr_sel;
    assign dmi_wr_ok = dmi_wen & debug_en & (dmi_addr == DMI_RD_PTR_ADDR);

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            rd_ptr_dw <= '0;
        end else if (fab_wr_ok) begin
            // Fabric has priority over the debug module
            // Depth is a power of two so the mask keeps it in range
            rd_ptr_dw <= fab_rd_ptr_new & 32'(DEPTH_DW - 1);
        end else if (dmi_wr_ok) begin
            rd_ptr_dw <= dmi_wdata & 32'(DEPTH_DW - 1);
        end
    end

endmodule

// ==== trace_storage.sv ====
`timescale 1ns/1ps

module trace_storage #(
    parameter int NUM_ENTRIES = 16
) (
    input  logic                           clk,
    input  logic                           rst_b,
    input  logic                           wr_en,
    input  logic [$clog2(NUM_ENTRIES)-1:0] wr_idx,
    input  trace_pkg::trace_entry_u        wr_entry,
    input  logic [31:0]                    rd_ptr_dw,
    output logic [31:0]                    rd_dword
);

    localparam int PTR_W = $clog2(NUM_ENTRIES);
    localparam int OFF_W = $clog2(trace_pkg::TRACE_ENTRY_DWORDS);

    // Circular entry array
    trace_pkg::trace_entry_u mem [NUM_ENTRIES];

    // Dword pointer split into entry and dword within the entry
    logic [PTR_W-1:0] rd_idx;
    logic [OFF_W-1:0] rd_off;

    //////////////////////////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            // Buffer reads back zero after reset
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_idx] <= wr_entry;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Dword read port
    //////////////////////////////////////////////////////////////////////
    assign rd_off = rd_ptr_dw[OFF_W-1:0];
    assign rd_idx = rd_ptr_dw[OFF_W +: PTR_W];

    // Read through the dword view of the union
    assign rd_dword = mem[rd_idx].dwords[rd_off];

endmodule

// ==== trace_capture.sv ====
`timescale 1ns/1ps

module trace_capture #(
    parameter int NUM_ENTRIES = 16
) (
    input  logic                           clk,
    input  logic                           rst_b,
    input  logic                           debug_en,
    input  logic                           trace_valid,
    input  logic [31:0]                    trace_insn,
    input  logic [31:0]                    trace_address,
    input  logic [31:0]                    trace_tval,
    input  logic                           trace_exception,
    input  logic [4:0]                     trace_ecause,
    input  logic                           trace_interrupt,
    output logic                           wr_en,
    output logic [$clog2(NUM_ENTRIES)-1:0] wr_idx,
    output trace_pkg::trace_entry_u        wr_entry,
    output logic [31:0]                    wr_ptr_dw,
    output logic                           valid_data,
    output logic                           wrapped
);

    localparam int PTR_W = $clog2(NUM_ENTRIES);

    // Entry index of the next write
    logic [PTR_W-1:0] ptr;

    // Strobes only count while debug is enabled
    assign wr_en  = trace_valid & debug_en;
    assign wr_idx = ptr;

    // Fill the entry by field
    // Clearing the whole entry first leaves the reserved bits zero
    always_comb begin
        wr_entry                  = '0;
        wr_entry.fields.interrupt = trace_interrupt;
        wr_entry.fields.ecause    = trace_ecause;
        wr_entry.fields.exception = trace_exception;
        wr_entry.fields.tval      = trace_tval;
        wr_entry.fields.address   = trace_address;
        wr_entry.fields.insn      = trace_insn;
    end

    //////////////////////////////////////////////////////////////////////
    // Write pointer and sticky flags
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            ptr        <= '0;
            valid_data <= 1'b0;
            wrapped    <= 1'b0;
        end else if (wr_en) begin
            valid_data <= 1'b1;
            // Next write after the last entry starts over at entry 0
            if (ptr == PTR_W'(NUM_ENTRIES - 1)) begin
                ptr     <= '0;
                wrapped <= 1'b1;
            end else begin
                ptr <= ptr + 1'b1;
            end
        end
    end

    // Software sees the pointer in dwords
    assign wr_ptr_dw = 32'(ptr) * 32'(trace_pkg::TRACE_ENTRY_DWORDS);

endmodule

// ==== trace_pkg.sv ====
package trace_pkg;

    //////////////////////////////////////////////////////////////////////
    // Trace entry layout
    //////////////////////////////////////////////////////////////////////

    // Number of dwords in one trace entry
    localparam int TRACE_ENTRY_DWORDS = 4;

    // Field view of one entry with the most significant field first
    // Dword 0 insn, dword 1 address, dword 2 tval, dword 3 cause flags
    typedef struct packed {
        logic [24:0] reserved;
        logic        interrupt;
        logic [4:0]  ecause;
        logic        exception;
        logic [31:0] tval;
        logic [31:0] address;
        logic [31:0] insn;
    } trace_fields_t;

    // Same 128 bits seen by field on capture and by dword on readback
    typedef union packed {
        trace_fields_t                         fields;
        logic [TRACE_ENTRY_DWORDS-1:0][31:0]   dwords;
    } trace_entry_u;

    //////////////////////////////////////////////////////////////////////
    // Fabric and debug views
    //////////////////////////////////////////////////////////////////////

    // Internal fabric request with a byte address
    typedef struct packed {
        logic [6:0]  addr;
        logic        write;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } fabric_req_t;

    // Packed register view seen by the debug module
    // cfg is the CONFIG register
    typedef struct packed {
        logic [31:0] status;
        logic [31:0] cfg;
        logic [31:0] wr_ptr;
        logic [31:0] rd_ptr;
        logic [31:0] data;
    } trace_dmi_view_t;

    // Register byte offsets on the fabric
    localparam logic [6:0] TRACE_STATUS_OFFS = 7'h00;
    localparam logic [6:0] TRACE_CONFIG_OFFS = 7'h04;
    localparam logic [6:0] TRACE_WR_PTR_OFFS = 7'h08;
    localparam logic [6:0] TRACE_RD_PTR_OFFS = 7'h0C;
    localparam logic [6:0] TRACE_DATA_OFFS   = 7'h10;

endpackage
